//--- Makefile
TOOL       = verilator
TOP        = rv32i_core_tb
FILELIST   = rv32i_core.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rv32i_core.f
+incdir+src
src/rv32i_pkg.sv
src/rv32i_decoder.sv
src/rv32i_regfile.sv
src/rv32i_alu.sv
src/rv32i_branch_unit.sv
src/rv32i_lsu.sv
src/rv32i_core.sv
testbench/rv32i_core_properties.sv
testbench/rv32i_core_tb.sv

//--- src/rv32i_alu.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module rv32i_alu (
  input  rv32i_pkg::alu_op_t       op,
  input  logic [`RV32I_XLEN-1:0]   a,
  input  logic [`RV32I_XLEN-1:0]   b,
  output logic [`RV32I_XLEN-1:0]   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      rv32i_pkg::alu_add:    result = a + b;
      rv32i_pkg::alu_sub:    result = a - b;
      rv32i_pkg::alu_sll:    result = a << shamt;
      rv32i_pkg::alu_slt:    result = {{(`RV32I_XLEN-1){1'b0}}, lt_signed};
      rv32i_pkg::alu_sltu:   result = {{(`RV32I_XLEN-1){1'b0}}, lt_unsigned};
      rv32i_pkg::alu_xor:    result = a ^ b;
      rv32i_pkg::alu_srl:    result = a >> shamt;
      rv32i_pkg::alu_sra:    result = $unsigned($signed(a) >>> shamt);
      rv32i_pkg::alu_or:     result = a | b;
      rv32i_pkg::alu_and:    result = a & b;
      rv32i_pkg::alu_pass_b: result = b;
      default:               result = '0;
    endcase
  end

endmodule

//--- src/rv32i_branch_unit.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module rv32i_branch_unit (
  input  logic [`RV32I_XLEN-1:0] pc,
  input  logic [`RV32I_XLEN-1:0] rs1_value,
  input  logic [`RV32I_XLEN-1:0] rs2_value,
  input  logic [`RV32I_XLEN-1:0] imm,
  input  rv32i_pkg::branch_t     branch,
  input  logic                   jal,
  input  logic                   jalr,
  input  logic                   halt,
  output logic [`RV32I_XLEN-1:0] pc_next
);

  logic                   taken;
  logic [`RV32I_XLEN-1:0] jalr_target;

  always_comb begin
    case (branch)
      rv32i_pkg::br_beq:  taken = (rs1_value == rs2_value);
      rv32i_pkg::br_bne:  taken = (rs1_value != rs2_value);
      rv32i_pkg::br_blt:  taken = ($signed(rs1_value) < $signed(rs2_value));
      rv32i_pkg::br_bge:  taken = ($signed(rs1_value) >= $signed(rs2_value));
      rv32i_pkg::br_bltu: taken = (rs1_value < rs2_value);
      rv32i_pkg::br_bgeu: taken = (rs1_value >= rs2_value);
      default:            taken = 1'b0;
    endcase
  end

  assign jalr_target = (rs1_value + imm) & ~`RV32I_XLEN'd1;

  always_comb begin
    if (halt) begin
      pc_next = pc;                     // Hold on ebreak
    end else if (jalr) begin
      pc_next = jalr_target;
    end else if (jal || taken) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + `RV32I_XLEN'd4;
    end
  end

endmodule

//--- src/rv32i_core.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module rv32i_core (
  input  logic                   clk,
  input  logic                   reset,
  output logic [`RV32I_XLEN-1:0] pc,
  input  logic [31:0]            ist,
  output logic                   mem_valid,
  output logic [`RV32I_XLEN-1:0] mem_raddr,
  input  logic [`RV32I_XLEN-1:0] mem_rdata,
  output logic                   mem_wen,
  output logic [`RV32I_XLEN-1:0] mem_waddr,
  output logic [`RV32I_XLEN-1:0] mem_wdata,
  output logic [3:0]             mem_wmask,
  output logic                   halted
);

  logic [`RV32I_REG_AW-1:0] rs1;
  logic [`RV32I_REG_AW-1:0] rs2;
  logic [`RV32I_REG_AW-1:0] rd;
  logic [`RV32I_XLEN-1:0]   imm;
  rv32i_pkg::alu_op_t       alu_op;
  logic                     alu_src_imm;
  logic                     alu_src_pc;
  logic                     rf_wen;
  rv32i_pkg::wb_sel_t       wb_sel;
  rv32i_pkg::branch_t       branch;
  logic                     jal;
  logic                     jalr;
  logic                     load;
  logic                     store;
  rv32i_pkg::mem_size_t     mem_size;
  logic                     load_unsigned;
  logic                     ebreak;
  logic                     illegal;
  logic                     stop;
  logic [`RV32I_XLEN-1:0]   rs1_value;
  logic [`RV32I_XLEN-1:0]   rs2_value;
  logic [`RV32I_XLEN-1:0]   alu_a;
  logic [`RV32I_XLEN-1:0]   alu_b;
  logic [`RV32I_XLEN-1:0]   alu_result;
  logic [`RV32I_XLEN-1:0]   load_value;
  logic [`RV32I_XLEN-1:0]   wb_value;
  logic [`RV32I_XLEN-1:0]   pc_next;

  rv32i_decoder decoder_i (
    .ist(ist), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .alu_src_imm(alu_src_imm), .alu_src_pc(alu_src_pc),
    .rf_wen(rf_wen), .wb_sel(wb_sel), .branch(branch), .jal(jal), .jalr(jalr),
    .load(load), .store(store), .mem_size(mem_size), .load_unsigned(load_unsigned),
    .ebreak(ebreak), .illegal(illegal)
  );

  // Unknown encodings stop the core like ebreak
  assign stop = halted | ebreak | illegal;

  rv32i_regfile regfile_i (
    .clk(clk), .raddr1(rs1), .raddr2(rs2), .waddr(rd),
    .wdata(wb_value), .wen(rf_wen & ~halted),
    .rdata1(rs1_value), .rdata2(rs2_value)
  );

  assign alu_a = alu_src_pc ? pc : rs1_value;    // auipc
  assign alu_b = alu_src_imm ? imm : rs2_value;

  rv32i_alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

  rv32i_branch_unit branch_unit_i (
    .pc(pc), .rs1_value(rs1_value), .rs2_value(rs2_value), .imm(imm),
    .branch(branch), .jal(jal), .jalr(jalr), .halt(stop), .pc_next(pc_next)
  );

  rv32i_lsu lsu_i (
    .base(rs1_value), .offset(imm), .store_value(rs2_value), .mem_rdata(mem_rdata),
    .load(load & ~halted), .store(store & ~halted), .size(mem_size),
    .load_unsigned(load_unsigned), .mem_valid(mem_valid), .mem_raddr(mem_raddr),
    .mem_wen(mem_wen), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
    .mem_wmask(mem_wmask), .load_value(load_value)
  );

  always_comb begin
    case (wb_sel)
      rv32i_pkg::wb_load:     wb_value = load_value;
      rv32i_pkg::wb_pc_plus4: wb_value = pc + `RV32I_XLEN'd4;
      default:                wb_value = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= `RV32I_RESET_PC;
      halted <= 1'b0;
    end else begin
      pc     <= pc_next;
      halted <= stop;                   // Sticky until reset
    end
  end

endmodule

//--- src/rv32i_decoder.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module rv32i_decoder (
  input  logic [31:0]                ist,
  output logic [`RV32I_REG_AW-1:0]   rs1,
  output logic [`RV32I_REG_AW-1:0]   rs2,
  output logic [`RV32I_REG_AW-1:0]   rd,
  output logic [`RV32I_XLEN-1:0]     imm,
  output rv32i_pkg::alu_op_t         alu_op,
  output logic                       alu_src_imm,
  output logic                       alu_src_pc,
  output logic                       rf_wen,
  output rv32i_pkg::wb_sel_t         wb_sel,
  output rv32i_pkg::branch_t         branch,
  output logic                       jal,
  output logic                       jalr,
  output logic                       load,
  output logic                       store,
  output rv32i_pkg::mem_size_t       mem_size,
  output logic                       load_unsigned,
  output logic                       ebreak,
  output logic                       illegal
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  rv32i_pkg::imm_fmt_t imm_fmt;
  rv32i_pkg::alu_op_t  arith_op;
  logic                imm_ok;
  logic                reg_ok;

  assign opcode = ist[6:0];
  assign funct3 = ist[14:12];
  assign funct7 = ist[31:25];
  assign rs1    = ist[19:15];
  assign rs2    = ist[24:20];
  assign rd     = ist[11:7];

  // Shared funct3 map of OP and OP-IMM where ist[30] picks sub or sra
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode[5] && ist[30]) ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
      3'b001:  arith_op = rv32i_pkg::alu_sll;
      3'b010:  arith_op = rv32i_pkg::alu_slt;
      3'b011:  arith_op = rv32i_pkg::alu_sltu;
      3'b100:  arith_op = rv32i_pkg::alu_xor;
      3'b101:  arith_op = ist[30] ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
      3'b110:  arith_op = rv32i_pkg::alu_or;
      default: arith_op = rv32i_pkg::alu_and;
    endcase
  end

  assign imm_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                  (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                  1'b1;
  assign reg_ok = (funct7 == 7'b0000000) ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    imm_fmt       = rv32i_pkg::imm_none;
    alu_op        = rv32i_pkg::alu_add;
    alu_src_imm   = 1'b0;
    alu_src_pc    = 1'b0;
    rf_wen        = 1'b0;
    wb_sel        = rv32i_pkg::wb_alu;
    branch        = rv32i_pkg::br_none;
    jal           = 1'b0;
    jalr          = 1'b0;
    load          = 1'b0;
    store         = 1'b0;
    mem_size      = rv32i_pkg::mem_size_t'(funct3[1:0]);
    load_unsigned = funct3[2];
    ebreak        = 1'b0;
    illegal       = 1'b0;
    case (opcode)
      7'b0110111: begin                 // lui
        imm_fmt     = rv32i_pkg::imm_u;
        alu_op      = rv32i_pkg::alu_pass_b;
        alu_src_imm = 1'b1;
        rf_wen      = 1'b1;
      end
      7'b0010111: begin                 // auipc
        imm_fmt     = rv32i_pkg::imm_u;
        alu_src_imm = 1'b1;
        alu_src_pc  = 1'b1;
        rf_wen      = 1'b1;
      end
      7'b1101111: begin
        imm_fmt = rv32i_pkg::imm_j;
        jal     = 1'b1;
        rf_wen  = 1'b1;
        wb_sel  = rv32i_pkg::wb_pc_plus4;
      end
      7'b1100111: begin
        imm_fmt = rv32i_pkg::imm_i;
        jalr    = (funct3 == 3'b000);
        rf_wen  = (funct3 == 3'b000);
        wb_sel  = rv32i_pkg::wb_pc_plus4;
        illegal = (funct3 != 3'b000);
      end
      7'b1100011: begin
        imm_fmt = rv32i_pkg::imm_b;
        case (funct3)
          3'b000:  branch = rv32i_pkg::br_beq;
          3'b001:  branch = rv32i_pkg::br_bne;
          3'b100:  branch = rv32i_pkg::br_blt;
          3'b101:  branch = rv32i_pkg::br_bge;
          3'b110:  branch = rv32i_pkg::br_bltu;
          3'b111:  branch = rv32i_pkg::br_bgeu;
          default: illegal = 1'b1;
        endcase
      end
      7'b0000011: begin
        imm_fmt = rv32i_pkg::imm_i;
        wb_sel  = rv32i_pkg::wb_load;
        if (funct3 == 3'b011 || funct3 == 3'b110 || funct3 == 3'b111)
          illegal = 1'b1;
        else begin
          load   = 1'b1;
          rf_wen = 1'b1;
        end
      end
      7'b0100011: begin
        imm_fmt = rv32i_pkg::imm_s;
        store   = (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010);
        illegal = !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010);
      end
      7'b0010011: begin
        imm_fmt     = rv32i_pkg::imm_i;
        alu_op      = arith_op;
        alu_src_imm = 1'b1;
        rf_wen      = imm_ok;
        illegal     = !imm_ok;
      end
      7'b0110011: begin
        alu_op  = arith_op;
        rf_wen  = reg_ok;
        illegal = !reg_ok;
      end
      7'b1110011: begin
        ebreak  = (ist == 32'h0010_0073);
        illegal = (ist != 32'h0010_0073);  // Only ebreak is supported
      end
      default: illegal = 1'b1;
    endcase
  end

  always_comb begin
    case (imm_fmt)
      rv32i_pkg::imm_i: imm = {{20{ist[31]}}, ist[31:20]};
      rv32i_pkg::imm_s: imm = {{20{ist[31]}}, ist[31:25], ist[11:7]};
      rv32i_pkg::imm_b: imm = {{20{ist[31]}}, ist[7], ist[30:25], ist[11:8], 1'b0};
      rv32i_pkg::imm_u: imm = {ist[31:12], 12'b0};
      rv32i_pkg::imm_j: imm = {{12{ist[31]}}, ist[19:12], ist[20], ist[30:21], 1'b0};
      default:          imm = '0;
    endcase
  end

endmodule

//--- src/rv32i_defines.svh
`ifndef RV32I_DEFINES_SVH
`define RV32I_DEFINES_SVH

// Data and address width
`define RV32I_XLEN 32

// Architectural integer registers
`define RV32I_REG_COUNT 32

// Register index width
`define RV32I_REG_AW 5

// First fetch address after reset
`define RV32I_RESET_PC 32'h8000_0000

`endif

//--- src/rv32i_lsu.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module rv32i_lsu (
  input  logic [`RV32I_XLEN-1:0] base,
  input  logic [`RV32I_XLEN-1:0] offset,
  input  logic [`RV32I_XLEN-1:0] store_value,
  input  logic [`RV32I_XLEN-1:0] mem_rdata,
  input  logic                   load,
  input  logic                   store,
  input  rv32i_pkg::mem_size_t   size,
  input  logic                   load_unsigned,
  output logic                   mem_valid,
  output logic [`RV32I_XLEN-1:0] mem_raddr,
  output logic                   mem_wen,
  output logic [`RV32I_XLEN-1:0] mem_waddr,
  output logic [`RV32I_XLEN-1:0] mem_wdata,
  output logic [3:0]             mem_wmask,
  output logic [`RV32I_XLEN-1:0] load_value
);

  logic [`RV32I_XLEN-1:0] addr;
  logic [4:0]             lane_shift;
  logic [`RV32I_XLEN-1:0] rdata_lane;
  logic [3:0]             size_mask;

  assign addr       = base + offset;
  assign lane_shift = {addr[1:0], 3'b000};

  assign mem_valid = load;
  assign mem_raddr = load ? addr : '0;
  assign mem_wen   = store;
  assign mem_waddr = addr;
  assign mem_wdata = store_value << lane_shift;  // Data into its byte lanes

  always_comb begin
    case (size)
      rv32i_pkg::size_byte: size_mask = 4'b0001;
      rv32i_pkg::size_half: size_mask = 4'b0011;
      default:              size_mask = 4'b1111;
    endcase
  end

  assign mem_wmask = store ? (size_mask << addr[1:0]) : 4'b0000;

  // Addressed lane moved down to bit 0
  assign rdata_lane = mem_rdata >> lane_shift;

  always_comb begin
    case (size)
      rv32i_pkg::size_byte:
        load_value = {{24{rdata_lane[7] & ~load_unsigned}}, rdata_lane[7:0]};
      rv32i_pkg::size_half:
        load_value = {{16{rdata_lane[15] & ~load_unsigned}}, rdata_lane[15:0]};
      default:
        load_value = mem_rdata;
    endcase
  end

endmodule

//--- src/rv32i_pkg.sv
package rv32i_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b                // lui
  } alu_op_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_pc_plus4               // Link value for jal and jalr
  } wb_sel_t;

  typedef enum logic [2:0] {
    br_none,
    br_beq,
    br_bne,
    br_blt,
    br_bge,
    br_bltu,
    br_bgeu
  } branch_t;

  // Encodings match funct3 bits 1 to 0 of loads and stores
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_t;

  typedef enum logic [2:0] {
    imm_none,
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_fmt_t;

endpackage

//--- src/rv32i_regfile.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module rv32i_regfile (
  input  logic                     clk,
  input  logic [`RV32I_REG_AW-1:0] raddr1,
  input  logic [`RV32I_REG_AW-1:0] raddr2,
  input  logic [`RV32I_REG_AW-1:0] waddr,
  input  logic [`RV32I_XLEN-1:0]   wdata,
  input  logic                     wen,
  output logic [`RV32I_XLEN-1:0]   rdata1,
  output logic [`RV32I_XLEN-1:0]   rdata2
);

  logic [`RV32I_XLEN-1:0] regs [`RV32I_REG_COUNT];

  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin       // x0 never written
      regs[waddr] <= wdata;
    end
  end

  // Reads see the old value during a write cycle
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- testbench/rv32i_core_properties.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module rv32i_core_properties (
  input logic                   clk,
  input logic                   reset,
  input logic [`RV32I_XLEN-1:0] pc,
  input logic                   mem_valid,
  input logic                   mem_wen,
  input logic [3:0]             mem_wmask,
  input logic                   halted
);

  // One data access per instruction
  no_load_with_store: assert property (
    @(posedge clk) disable iff (reset) !(mem_valid && mem_wen))
    else $error("mem_valid and mem_wen high in the same cycle");

  idle_mask_zero: assert property (
    @(posedge clk) disable iff (reset) !mem_wen |-> (mem_wmask == 4'b0000))
    else $error("mem_wmask nonzero without mem_wen");

  pc_word_aligned: assert property (
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  halt_holds_pc: assert property (
    @(posedge clk) disable iff (reset) halted |=> $stable(pc))
    else $error("pc moved while halted");

endmodule

//--- testbench/rv32i_core_tb.sv
`timescale 1ns/1ps
`include "rv32i_defines.svh"

module rv32i_core_tb;

  localparam int num_instr  = 2000;
  localparam int preload    = 31;       // x1..x30 random, x31 window base
  localparam int clk_period = 8;

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] ist;
  logic        mem_valid;
  logic [31:0] mem_raddr;
  logic [31:0] mem_rdata;
  logic        mem_wen;
  logic [31:0] mem_waddr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wmask;
  logic        halted;
  logic [31:0] regs [32];
  logic [31:0] dmem [256];
  logic [31:0] model_pc;
  logic [4:0]  mirror_rd;

  rv32i_core dut_i (
    .clk(clk), .reset(reset), .pc(pc), .ist(ist), .mem_valid(mem_valid),
    .mem_raddr(mem_raddr), .mem_rdata(mem_rdata), .mem_wen(mem_wen),
    .mem_waddr(mem_waddr), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask), .halted(halted)
  );

  bind rv32i_core rv32i_core_properties props_i (
    .clk(clk), .reset(reset), .pc(pc), .mem_valid(mem_valid), .mem_wen(mem_wen),
    .mem_wmask(mem_wmask), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #((num_instr + 100) * clk_period);
    $display("Timeout: the instruction stream did not finish in time");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error: %s is %h, expected %h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // RV32I OP and OP-IMM semantics by funct3
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'd0: return alt ? x - y : x + y;
      3'd1: return x << y[4:0];
      3'd2: return {31'b0, $signed(x) < $signed(y)};
      3'd3: return {31'b0, x < y};
      3'd4: return x ^ y;
      3'd5: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6: return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic step_instruction(input int n);
    logic [31:0] a, b, imm, res, addr, word, exp_wdata, next_pc;
    logic [11:0] imm12;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [3:0]  exp_mask;
    logic        wr, alt, taken, exp_valid, exp_wen;
    int          kind;
    rd = 5'($urandom_range(0, 30));       // x31 stays the window base
    rs1 = 5'($urandom);
    rs2 = 5'($urandom);
    f3 = 3'($urandom);
    alt = 1'($urandom);
    imm12 = 12'($urandom);
    kind = (n < preload) ? 0 : (n % 4 == 3) ? 1 : $urandom_range(2, 10);
    {wr, exp_valid, exp_wen, exp_mask} = '0;
    {res, addr, imm, exp_wdata} = '0;
    next_pc = model_pc + 32'd4;
    if (kind == 1) f3 = 3'd2;
    if (kind == 10) f3 = 3'($urandom_range(0, 2));
    if (kind == 9) begin
      f3 = 3'($urandom_range(0, 4));
      if (f3 >= 3'd3) f3 = f3 + 3'd1;    // lbu, lhu
    end
    if (kind == 6) begin
      f3 = 3'($urandom_range(0, 5));
      if (f3 >= 3'd2) f3 = f3 + 3'd2;
      if ($urandom_range(0, 3) == 0) rs2 = rs1;
    end
    if (kind == 1 || kind >= 9) rs1 = ($urandom_range(0, 1) != 0) ? 5'd31 : 5'd0;
    if (kind == 1) rs2 = mirror_rd;
    if (kind == 0 || kind == 8) rs1 = 5'd0;
    a = regs[rs1];
    b = regs[rs2];
    if (kind == 1 || kind >= 9) begin
      addr = 32'($urandom_range(0, 1023)) & ~((32'd1 << f3[1:0]) - 32'd1);
      imm = addr - a;
      imm12 = imm[11:0];
    end
    if (kind == 6 || kind == 7) imm = 32'($urandom_range(0, 31)) * 4 - 64;
    case (kind)
      0: begin
        if (n == preload - 1) begin
          rd = 5'd31;
          imm12 = 12'h200;
        end else begin
          rd = 5'(n + 1);
        end
        res = {{20{imm12[11]}}, imm12};
        wr = 1'b1;
        ist = {imm12, 5'd0, 3'b000, rd, 7'b0010011};
      end
      1, 10: begin
        exp_wen = 1'b1;
        exp_wdata = b << {addr[1:0], 3'b000};
        exp_mask = (f3 == 3'd0 ? 4'b0001 : f3 == 3'd1 ? 4'b0011 : 4'b1111) << addr[1:0];
        ist = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
      end
      2, 3: begin
        imm = {20'($urandom), 12'b0};
        res = (kind == 2) ? imm : model_pc + imm;
        wr = 1'b1;
        ist = {imm[31:12], rd, (kind == 2) ? 7'b0110111 : 7'b0010111};
      end
      4: begin
        alt = alt & (f3 == 3'd5);
        if (f3 == 3'd1 || f3 == 3'd5) imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
        res = alu_model(f3, alt, a, {{20{imm12[11]}}, imm12});
        wr = 1'b1;
        ist = {imm12, rs1, f3, rd, 7'b0010011};
      end
      5: begin
        alt = alt & (f3 == 3'd0 || f3 == 3'd5);
        res = alu_model(f3, alt, a, b);
        wr = 1'b1;
        ist = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
      end
      6: begin
        case (f3)
          3'd0: taken = a == b;
          3'd1: taken = a != b;
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          default: taken = a >= b;
        endcase
        if (taken) next_pc = model_pc + imm;
        ist = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
      end
      7: begin
        res = model_pc + 32'd4;
        wr = 1'b1;
        next_pc = model_pc + imm;
        ist = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
      end
      8: begin
        imm12 = {1'b0, 9'($urandom), 1'b0, 1'($urandom)};  // Bit 0 set half the time
        res = model_pc + 32'd4;
        wr = 1'b1;
        next_pc = {20'b0, imm12[11:1], 1'b0};
        ist = {imm12, 5'd0, 3'b000, rd, 7'b1100111};
      end
      default: begin
        word = dmem[addr[9:2]] >> {addr[1:0], 3'b000};
        case (f3)
          3'd0: res = {{24{word[7]}}, word[7:0]};
          3'd1: res = {{16{word[15]}}, word[15:0]};
          3'd4: res = {24'b0, word[7:0]};
          3'd5: res = {16'b0, word[15:0]};
          default: res = word;
        endcase
        wr = 1'b1;
        exp_valid = 1'b1;
        ist = {imm12, rs1, f3, rd, 7'b0000011};
      end
    endcase
    #1;
    mem_rdata = dmem[mem_raddr[9:2]];
    compare_value("mem_valid", 32'(mem_valid), 32'(exp_valid));
    if (exp_valid) compare_value("mem_raddr", mem_raddr, addr);
    compare_value("mem_wen", 32'(mem_wen), 32'(exp_wen));
    if (exp_wen) begin
      compare_value("mem_waddr", mem_waddr, addr);
      compare_value("mem_wdata", mem_wdata, exp_wdata);
      compare_value("mem_wmask", 32'(mem_wmask), 32'(exp_mask));
      for (int i = 0; i < 4; i++) begin
        if (exp_mask[i]) dmem[addr[9:2]][8*i +: 8] = exp_wdata[8*i +: 8];
      end
    end
    if (wr) mirror_rd = rd;             // Next mirror store reads it back
    if (wr && rd != 5'd0) regs[rd] = res;
    model_pc = next_pc;
  endtask

  initial begin
    void'($urandom(32'hb007));
    reset = 1'b1;
    ist = 32'h0000_0013;
    mem_rdata = '0;
    mirror_rd = '0;
    for (int i = 0; i < 256; i++) begin
      dmem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    end
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    compare_value("pc", pc, `RV32I_RESET_PC);
    model_pc = `RV32I_RESET_PC;
    for (int n = 0; n < num_instr + preload; n++) begin
      compare_value("pc", pc, model_pc);
      compare_value("halted", 32'(halted), 32'd0);
      step_instruction(n);
      @(posedge clk);
      #1;
    end
    ist = 32'h0010_0073;                // ebreak
    repeat (4) begin
      @(posedge clk);
      #1;
      compare_value("pc", pc, model_pc);
      compare_value("halted", 32'(halted), 32'd1);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule
